//--- rtl/cache_pkg.sv
package cache_pkg;

	// address and data geometry
	// --------------------
	localparam int BW_BLOCK     = 3;   // eight words per block
	localparam int BW_WORD_ADDR = 16;  // word addressed memory
	localparam int BW_DATA      = 32;

	// replacement policy ids
	localparam string POLICY_FIFO = "FIFO";
	localparam string POLICY_PLRU = "PLRU";

	// ceiling log2, for line, group and tag widths
	function automatic int clog2_f(input int value);
		int result;
		result = 0;
		while ((1 << result) < value) begin
			result++;
		end
		return result;
	endfunction

endpackage

//--- rtl/cache_tag_cam.sv
`timescale 1ns/100ps

module cache_tag_cam
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 32,
	localparam int BW_LINE = clog2_f(CACHE_BLOCK_CAPACITY),
	localparam int BW_GRP  = BW_LINE - 3,
	localparam int BW_TAG  = BW_WORD_ADDR - BW_GRP - BW_BLOCK
)(
	input  logic               clock_i,
	input  logic               resetn_i,
	input  logic [BW_TAG-1:0]  tag_i,      // lookup tag, also the tag written
	input  logic [BW_GRP-1:0]  group_i,
	input  logic               wren_i,
	input  logic [BW_LINE-1:0] waddr_i,
	input  logic [BW_LINE-1:0] rd_addr_i,  // line whose tag goes out on tag_o
	output logic               hit_o,
	output logic [BW_LINE-1:0] addr_o,     // matching line
	output logic [BW_TAG-1:0]  tag_o
);

	logic [BW_TAG-1:0]               tag_mem [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_reg;
	logic [7:0]                      match;
	logic [2:0]                      way_sel;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_reg <= '0;
		end else if (wren_i) begin
			valid_reg[waddr_i] <= 1'b1;  // lines never invalidate, only get replaced
		end
	end

	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tag_mem[waddr_i] <= tag_i;
		end
	end

	// one comparator per way of the addressed set
	for (genvar w = 0; w < 8; w++) begin : g_way
		assign match[w] = valid_reg[{group_i, 3'(w)}] && (tag_mem[{group_i, 3'(w)}] == tag_i);
	end

	// at most one way can match
	always_comb begin
		way_sel = '0;
		for (int w = 0; w < 8; w++) begin
			if (match[w]) begin
				way_sel = 3'(w);
			end
		end
	end

	assign hit_o  = |match;
	assign addr_o = {group_i, way_sel};
	assign tag_o  = tag_mem[rd_addr_i];  // victim tag for the writeback address

endmodule

//--- rtl/cache_data_mem.sv
`timescale 1ns/100ps

module cache_data_mem
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 32,
	localparam int BW_ADDR = clog2_f(CACHE_BLOCK_CAPACITY) + BW_BLOCK
)(
	input  logic               clock_i,
	input  logic [BW_ADDR-1:0] addr_i,   // {line, word}
	input  logic               rw_i,     // 1 = write
	input  logic [BW_DATA-1:0] data_i,
	output logic [BW_DATA-1:0] data_o
);

	logic [BW_DATA-1:0] mem [CACHE_BLOCK_CAPACITY << BW_BLOCK];

	// read before write on the same address
	always_ff @(posedge clock_i) begin
		if (rw_i) begin
			mem[addr_i] <= data_i;
		end
		data_o <= mem[addr_i];  // registered read, every cycle
	end

endmodule

//--- rtl/cache_replacement_policy.sv
`timescale 1ns/100ps

module cache_replacement_policy
	import cache_pkg::*;
#(
	parameter string POLICY = POLICY_FIFO,
	parameter int CACHE_BLOCK_CAPACITY = 32,
	localparam int BW_LINE = clog2_f(CACHE_BLOCK_CAPACITY),
	localparam int BW_GRP  = BW_LINE - 3,
	localparam int N_SETS  = CACHE_BLOCK_CAPACITY / 8
)(
	input  logic               clock_i,
	input  logic               resetn_i,
	input  logic               hit_i,       // pulse, line on hit_addr_i was used
	input  logic               miss_i,      // pulse, pick a victim in group_i
	input  logic [BW_LINE-1:0] hit_addr_i,
	input  logic [BW_GRP-1:0]  group_i,
	output logic               done_o,
	output logic [BW_LINE-1:0] addr_o       // victim line
);

	logic [2:0] victim_way;

	// tree walk, each node bit points at the older half
	function automatic logic [2:0] plru_victim(input logic [6:0] t);
		logic b0;
		logic b1;
		logic b2;
		b0 = t[0];
		b1 = b0 ? t[2] : t[1];
		b2 = t[{1'b1, b0, b1} - 3'd1];  // nodes 3..6
		return {b0, b1, b2};
	endfunction

	// point every node on the path away from way w
	function automatic logic [6:0] plru_touch(input logic [6:0] t, input logic [2:0] w);
		logic [6:0] n;
		n = t;
		n[0] = ~w[2];
		n[{2'b00, w[2]} + 3'd1] = ~w[1];
		n[{1'b1, w[2], w[1]} - 3'd1] = ~w[0];
		return n;
	endfunction

	if (POLICY == POLICY_PLRU) begin : g_plru
		logic [6:0] tree_reg [N_SETS];

		assign victim_way = plru_victim(tree_reg[group_i]);

		always_ff @(posedge clock_i) begin
			if (!resetn_i) begin
				for (int s = 0; s < N_SETS; s++) begin
					tree_reg[s] <= '0;
				end
			end else if (hit_i) begin
				tree_reg[hit_addr_i[BW_LINE-1:3]] <=
					plru_touch(tree_reg[hit_addr_i[BW_LINE-1:3]], hit_addr_i[2:0]);
			end else if (miss_i) begin
				tree_reg[group_i] <= plru_touch(tree_reg[group_i], victim_way);  // fill counts as use
			end
		end
	end else begin : g_fifo
		logic [2:0] ptr_reg [N_SETS];  // oldest way per set

		assign victim_way = ptr_reg[group_i];

		always_ff @(posedge clock_i) begin
			if (!resetn_i) begin
				for (int s = 0; s < N_SETS; s++) begin
					ptr_reg[s] <= '0;
				end
			end else if (miss_i) begin
				ptr_reg[group_i] <= ptr_reg[group_i] + 3'd1;  // round robin
			end
		end
	end

	// result one cycle after the miss pulse
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			done_o <= 1'b0;
		end else begin
			done_o <= miss_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (miss_i) begin
			addr_o <= {group_i, victim_way};
		end
	end

endmodule

//--- rtl/block_word_fifo.sv
`timescale 1ns/100ps

module block_word_fifo
	import cache_pkg::*;
#(
	parameter int FIFO_DEPTH = 8,
	localparam int BW_PTR = clog2_f(FIFO_DEPTH)
)(
	input  logic               clock_i,
	input  logic               resetn_i,
	input  logic               push_i,
	input  logic [BW_DATA-1:0] data_i,
	input  logic               pop_i,
	output logic [BW_DATA-1:0] data_o,       // head word
	output logic               not_empty_o,
	output logic               not_full_o
);

	logic [BW_DATA-1:0] mem [FIFO_DEPTH];
	logic [BW_PTR-1:0]  wr_ptr_reg;
	logic [BW_PTR-1:0]  rd_ptr_reg;
	logic [BW_PTR:0]    count_reg;
	logic               do_push;
	logic               do_pop;

	assign do_push = push_i && not_full_o;   // push on full is dropped
	assign do_pop  = pop_i && not_empty_o;

	// wrap for any depth
	function automatic logic [BW_PTR-1:0] ptr_inc(input logic [BW_PTR-1:0] p);
		return (p == BW_PTR'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_reg <= '0;
			rd_ptr_reg <= '0;
			count_reg  <= '0;
		end else begin
			if (do_push) wr_ptr_reg <= ptr_inc(wr_ptr_reg);
			if (do_pop)  rd_ptr_reg <= ptr_inc(rd_ptr_reg);
			if (do_push && !do_pop) count_reg <= count_reg + 1'b1;
			else if (do_pop && !do_push) count_reg <= count_reg - 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_push) begin
			mem[wr_ptr_reg] <= data_i;
		end
	end

	assign data_o      = mem[rd_ptr_reg];
	assign not_empty_o = (count_reg != '0);
	assign not_full_o  = (count_reg != (BW_PTR+1)'(FIFO_DEPTH));

endmodule

//--- rtl/cache_8way_controller.sv
`timescale 1ns/100ps

module cache_8way_controller
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 32,
	parameter string POLICY = POLICY_FIFO,
	localparam int BW_LINE = clog2_f(CACHE_BLOCK_CAPACITY),
	localparam int BW_GRP  = BW_LINE - 3,
	localparam int BW_TAG  = BW_WORD_ADDR - BW_GRP - BW_BLOCK
)(
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        enable_i,
	// core
	input  logic                        core_req_i,
	input  logic                        core_rw_i,
	input  logic [BW_TAG-1:0]           core_tag_i,
	input  logic [BW_GRP-1:0]           core_grp_i,
	input  logic [BW_BLOCK-1:0]         core_word_i,
	input  logic [BW_DATA-1:0]          core_data_i,
	output logic                        core_done_o,
	output logic                        core_hit_o,
	// tag cam
	input  logic                        cam_hit_i,
	input  logic [BW_LINE-1:0]          cam_addr_i,
	input  logic [BW_TAG-1:0]           cam_tag_i,
	output logic                        cam_wren_o,
	output logic [BW_LINE-1:0]          cam_addr_o,
	// data memory
	input  logic [BW_DATA-1:0]          cache_mem_data_i,
	output logic [BW_LINE+BW_BLOCK-1:0] cache_mem_addr_o,
	output logic                        cache_mem_rw_o,
	output logic [BW_DATA-1:0]          cache_mem_data_o,
	// fill and writeback buffers
	input  logic                        fill_ready_i,
	input  logic [BW_DATA-1:0]          fill_data_i,
	output logic                        fill_ack_o,
	input  logic                        wb_ready_i,
	output logic                        wb_push_o,
	output logic [BW_DATA-1:0]          wb_data_o,
	// memory commands
	input  logic                        mem_ready_i,
	output logic                        mem_req_o,
	output logic                        mem_rw_o,
	output logic [BW_WORD_ADDR-1:0]     mem_addr_o,
	// performance
	output logic                        flag_hit_o,
	output logic                        flag_miss_o,
	output logic                        flag_writeback_o
);

	typedef enum logic [2:0] {
		ST_NORMAL,
		ST_WAIT_READY,
		ST_WAIT_REPL,
		ST_WRITE_BUFFER,
		ST_READ_BUFFER
	} state_t;

	state_t                          state_reg;
	logic [BW_BLOCK-1:0]             xfer_cnt_reg;    // words moved in this block
	logic [CACHE_BLOCK_CAPACITY-1:0] dirty_reg;
	logic [BW_LINE-1:0]              victim_reg;
	logic                            victim_ok_reg;   // victim captured, not yet used
	logic                            req_flag_reg;    // replay pending after a miss
	logic                            rw_flag_reg;
	logic                            wb_pending_reg;  // block write still to be issued
	logic [BW_WORD_ADDR-1:0]         wb_addr_reg;
	logic                            data_ok_reg;     // read data matches xfer_cnt_reg
	logic                            repl_done;
	logic [BW_LINE-1:0]              repl_addr;
	logic                            store_now;
	logic                            last_word;
	logic [BW_BLOCK-1:0]             push_next;
	logic                            data_ok_next;
	logic [BW_BLOCK-1:0]             wb_word_next;

	// hit_addr from the registered hit line, core may already be on a new access
	cache_replacement_policy #(
		.POLICY               (POLICY),
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) policy_i (
		.clock_i    (clock_i),
		.resetn_i   (resetn_i),
		.hit_i      (flag_hit_o),
		.miss_i     (flag_miss_o),
		.hit_addr_i (cache_mem_addr_o[BW_LINE+BW_BLOCK-1:BW_BLOCK]),
		.group_i    (core_grp_i),
		.done_o     (repl_done),
		.addr_o     (repl_addr)
	);

	assign core_hit_o = (core_req_i | req_flag_reg) ? cam_hit_i : 1'b1;  // no stall when idle
	assign store_now  = req_flag_reg ? rw_flag_reg : core_rw_i;
	assign last_word  = &xfer_cnt_reg;

	// buffer strobes act in the same cycle so a word is never taken twice
	assign fill_ack_o = enable_i && (state_reg == ST_READ_BUFFER) && fill_ready_i;
	assign wb_push_o  = enable_i && (state_reg == ST_WRITE_BUFFER) && data_ok_reg && wb_ready_i;
	assign wb_data_o  = cache_mem_data_i;

	// writeback read pipeline
	// --------------------
	// address runs one word ahead of the push count, on a stall it falls back
	assign push_next    = xfer_cnt_reg + {{(BW_BLOCK-1){1'b0}}, wb_push_o};
	assign data_ok_next = (cache_mem_addr_o[BW_BLOCK-1:0] == push_next);
	assign wb_word_next = push_next + {{(BW_BLOCK-1){1'b0}}, data_ok_next};

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_reg        <= ST_NORMAL;
			xfer_cnt_reg     <= '0;
			dirty_reg        <= '0;
			victim_ok_reg    <= 1'b0;
			req_flag_reg     <= 1'b0;
			wb_pending_reg   <= 1'b0;
			data_ok_reg      <= 1'b0;
			core_done_o      <= 1'b1;  // ready for the first request
			cam_wren_o       <= 1'b0;
			cache_mem_rw_o   <= 1'b0;
			mem_req_o        <= 1'b0;
			mem_rw_o         <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
		end else begin
			// pulses
			cam_wren_o       <= 1'b0;
			cache_mem_rw_o   <= 1'b0;
			mem_req_o        <= 1'b0;
			mem_rw_o         <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;

			if (repl_done) begin  // policy answers whatever state we are in
				victim_reg    <= repl_addr;
				victim_ok_reg <= 1'b1;
			end

			if (enable_i) begin
				case (state_reg)
					ST_NORMAL: begin
						// replay holds off while the new tag is still being written
						if (core_req_i || (req_flag_reg && !cam_wren_o)) begin
							if (cam_hit_i) begin
								flag_hit_o       <= 1'b1;
								cache_mem_addr_o <= {cam_addr_i, core_word_i};
								cache_mem_rw_o   <= store_now;
								cache_mem_data_o <= core_data_i;  // ignored on loads
								if (store_now) dirty_reg[cam_addr_i] <= 1'b1;
								core_done_o      <= 1'b1;
								req_flag_reg     <= 1'b0;
							end else begin
								flag_miss_o  <= 1'b1;  // also starts the victim search
								req_flag_reg <= 1'b1;
								rw_flag_reg  <= core_rw_i;
								core_done_o  <= 1'b0;  // stall core
								state_reg    <= ST_WAIT_READY;
							end
						end
					end

					// old block write must go out before the next read
					ST_WAIT_READY: begin
						if (mem_ready_i && !wb_pending_reg) begin
							mem_req_o  <= 1'b1;
							mem_rw_o   <= 1'b0;
							mem_addr_o <= {core_tag_i, core_grp_i, {BW_BLOCK{1'b0}}};
							state_reg  <= ST_WAIT_REPL;
						end
					end

					ST_WAIT_REPL: begin
						if (victim_ok_reg) begin
							victim_ok_reg <= 1'b0;
							xfer_cnt_reg  <= '0;
							if (dirty_reg[victim_reg]) begin
								flag_writeback_o <= 1'b1;
								cam_addr_o       <= victim_reg;  // tag shows up next cycle
								cache_mem_addr_o <= {victim_reg, {BW_BLOCK{1'b0}}};
								data_ok_reg      <= 1'b0;
								state_reg        <= ST_WRITE_BUFFER;
							end else begin
								state_reg <= ST_READ_BUFFER;  // clean, just overwrite
							end
						end
					end

					ST_WRITE_BUFFER: begin
						xfer_cnt_reg     <= push_next;
						data_ok_reg      <= data_ok_next;
						cache_mem_addr_o <= {victim_reg, wb_word_next};
						if (wb_push_o) begin
							if (xfer_cnt_reg == '0) begin
								wb_addr_reg <= {cam_tag_i, core_grp_i, {BW_BLOCK{1'b0}}};
							end
							if (last_word) begin  // counter wraps to 0 for the fill
								wb_pending_reg <= 1'b1;
								state_reg      <= ST_READ_BUFFER;
							end
						end
					end

					ST_READ_BUFFER: begin
						if (fill_ack_o) begin
							cache_mem_rw_o   <= 1'b1;
							cache_mem_addr_o <= {victim_reg, xfer_cnt_reg};
							cache_mem_data_o <= fill_data_i;
							xfer_cnt_reg     <= xfer_cnt_reg + 1'b1;
							if (last_word) begin
								cam_wren_o            <= 1'b1;  // core tag into victim line
								cam_addr_o            <= victim_reg;
								dirty_reg[victim_reg] <= 1'b0;
								state_reg             <= ST_NORMAL;  // replay once the tag is in
							end
						end
					end

					default: state_reg <= ST_NORMAL;
				endcase

				// block write, independent of the state machine
				// --------------------
				if (wb_pending_reg && mem_ready_i) begin
					wb_pending_reg <= 1'b0;
					mem_req_o      <= 1'b1;
					mem_rw_o       <= 1'b1;
					mem_addr_o     <= wb_addr_reg;
				end
			end
		end
	end

endmodule

//--- rtl/cache_subsystem_top.sv
`timescale 1ns/100ps

module cache_subsystem_top
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 32,
	parameter string POLICY = POLICY_FIFO,
	parameter int FIFO_DEPTH = 8,
	localparam int BW_LINE = clog2_f(CACHE_BLOCK_CAPACITY),
	localparam int BW_GRP  = BW_LINE - 3,
	localparam int BW_TAG  = BW_WORD_ADDR - BW_GRP - BW_BLOCK
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    enable_i,
	// core
	input  logic                    core_req_i,
	input  logic                    core_rw_i,
	input  logic [BW_WORD_ADDR-1:0] core_addr_i,
	input  logic [BW_DATA-1:0]      core_data_i,
	output logic                    core_done_o,
	output logic                    core_hit_o,
	output logic [BW_DATA-1:0]      core_data_o,
	// memory commands
	output logic                    mem_req_o,
	output logic                    mem_rw_o,
	output logic [BW_WORD_ADDR-1:0] mem_addr_o,
	input  logic                    mem_ready_i,
	// fill and writeback words
	input  logic                    mem_rdata_valid_i,
	input  logic [BW_DATA-1:0]      mem_rdata_i,
	output logic                    mem_wdata_valid_o,
	input  logic                    mem_wdata_ack_i,
	output logic [BW_DATA-1:0]      mem_wdata_o,
	// performance
	output logic                    flag_hit_o,
	output logic                    flag_miss_o,
	output logic                    flag_writeback_o
);

	logic [BW_TAG-1:0]           core_tag;
	logic [BW_GRP-1:0]           core_grp;
	logic [BW_BLOCK-1:0]         core_word;
	logic                        cam_hit;
	logic [BW_LINE-1:0]          cam_line;  // matching line
	logic [BW_TAG-1:0]           cam_tag;
	logic                        cam_wren;
	logic [BW_LINE-1:0]          cam_addr;  // write line and tag read line
	logic [BW_LINE+BW_BLOCK-1:0] dmem_addr;
	logic                        dmem_rw;
	logic [BW_DATA-1:0]          dmem_wdata;
	logic                        fill_ready;
	logic [BW_DATA-1:0]          fill_data;
	logic                        fill_ack;
	logic                        wb_ready;
	logic                        wb_push;
	logic [BW_DATA-1:0]          wb_data;

	// {tag, group, word}
	assign core_tag  = core_addr_i[BW_WORD_ADDR-1 -: BW_TAG];
	assign core_grp  = core_addr_i[BW_BLOCK +: BW_GRP];
	assign core_word = core_addr_i[BW_BLOCK-1:0];

	cache_8way_controller #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY),
		.POLICY               (POLICY)
	) controller_i (
		.clock_i, .resetn_i, .enable_i,
		.core_req_i, .core_rw_i,
		.core_tag_i       (core_tag),
		.core_grp_i       (core_grp),
		.core_word_i      (core_word),
		.core_data_i, .core_done_o, .core_hit_o,
		.cam_hit_i        (cam_hit),
		.cam_addr_i       (cam_line),
		.cam_tag_i        (cam_tag),
		.cam_wren_o       (cam_wren),
		.cam_addr_o       (cam_addr),
		.cache_mem_data_i (core_data_o),
		.cache_mem_addr_o (dmem_addr),
		.cache_mem_rw_o   (dmem_rw),
		.cache_mem_data_o (dmem_wdata),
		.fill_ready_i     (fill_ready),
		.fill_data_i      (fill_data),
		.fill_ack_o       (fill_ack),
		.wb_ready_i       (wb_ready),
		.wb_push_o        (wb_push),
		.wb_data_o        (wb_data),
		.mem_ready_i, .mem_req_o, .mem_rw_o, .mem_addr_o,
		.flag_hit_o, .flag_miss_o, .flag_writeback_o
	);

	cache_tag_cam #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) tag_cam_i (
		.clock_i, .resetn_i,
		.tag_i     (core_tag),
		.group_i   (core_grp),
		.wren_i    (cam_wren),
		.waddr_i   (cam_addr),
		.rd_addr_i (cam_addr),
		.hit_o     (cam_hit),
		.addr_o    (cam_line),
		.tag_o     (cam_tag)
	);

	cache_data_mem #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) data_mem_i (
		.clock_i,
		.addr_i (dmem_addr),
		.rw_i   (dmem_rw),
		.data_i (dmem_wdata),
		.data_o (core_data_o)  // load data straight from the array
	);

	// memory -> cache
	block_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fill_buffer_i (
		.clock_i, .resetn_i,
		.push_i      (mem_rdata_valid_i),
		.data_i      (mem_rdata_i),
		.pop_i       (fill_ack),
		.data_o      (fill_data),
		.not_empty_o (fill_ready),
		.not_full_o  ()
	);

	// cache -> memory
	block_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) wb_buffer_i (
		.clock_i, .resetn_i,
		.push_i      (wb_push),
		.data_i      (wb_data),
		.pop_i       (mem_wdata_ack_i),
		.data_o      (mem_wdata_o),
		.not_empty_o (mem_wdata_valid_o),
		.not_full_o  (wb_ready)
	);

endmodule

//--- test/tb_main_memory.sv
`timescale 1ns/100ps

module tb_main_memory #(
	parameter logic [31:0] SEED = 32'h1
)(
	input  logic        clock_i,
	input  logic        slow_i,             // long ready and word gaps
	input  logic        mem_req_i,
	input  logic        mem_rw_i,
	input  logic [15:0] mem_addr_i,
	output logic        mem_ready_o,
	output logic        mem_rdata_valid_o,
	output logic [31:0] mem_rdata_o,
	input  logic        mem_wdata_valid_i,
	output logic        mem_wdata_ack_o,
	input  logic [31:0] mem_wdata_i
);

	logic [31:0] words [65536];
	logic [31:0] rand_state;
	int          block_writes;  // finished block writes, watched by the testbench

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_gap(output int gap);
		rand_state = next_rand(rand_state);
		gap = slow_i ? int'(rand_state[31:28]) : int'(rand_state[31]);
	endtask

	// one block, eight words, called on a falling edge
	task automatic serve_block(input logic rw, input logic [15:0] base);
		int gap;
		int w;
		mem_ready_o = 1'b0;  // busy until the block is done
		for (w = 0; w < 8; w++) begin
			draw_gap(gap);
			repeat (gap) @(negedge clock_i);
			if (rw) begin
				while (!mem_wdata_valid_i) @(negedge clock_i);
				words[base + 16'(w)] = mem_wdata_i;  // head word of the buffer
				mem_wdata_ack_o = 1'b1;
				@(negedge clock_i);
				mem_wdata_ack_o = 1'b0;
			end else begin
				mem_rdata_o       = words[base + 16'(w)];
				mem_rdata_valid_o = 1'b1;
				@(negedge clock_i);
				mem_rdata_valid_o = 1'b0;
			end
		end
		if (rw) block_writes++;
	endtask

	initial begin
		mem_ready_o       = 1'b0;
		mem_rdata_valid_o = 1'b0;
		mem_rdata_o       = '0;
		mem_wdata_ack_o   = 1'b0;
		block_writes      = 0;
		rand_state        = SEED;
		for (int i = 0; i < 65536; i++) begin
			words[i] = 32'(i) * 32'h9e3779b1 + 32'd1;  // address pattern
		end
		forever begin
			@(negedge clock_i);
			if (mem_req_i) begin
				serve_block(mem_rw_i, mem_addr_i);
			end else begin
				rand_state  = next_rand(rand_state);
				mem_ready_o = slow_i ? (rand_state[31:30] == 2'd0) : (rand_state[31:30] != 2'd0);
			end
		end
	end

endmodule

//--- test/tb_cache_subsystem.sv
`timescale 1ns/100ps

module tb_cache_subsystem;

	localparam int          PERIOD      = 40;
	localparam logic [31:0] SEED        = 32'hd4b682ae;
	localparam int          N_ACCESS    = 420;   // all accesses of all tests
	localparam int          WORST_MISS  = 1000;  // cycles, slow fill plus writeback
	localparam int          CYCLE_LIMIT = N_ACCESS * WORST_MISS;

	logic        clock;
	logic        resetn;
	logic        core_req;
	logic        core_rw;
	logic [15:0] core_addr;
	logic [31:0] core_data;
	logic        core_done_o;
	logic        core_hit_o;
	logic [31:0] core_data_o;
	logic        mem_req_o;
	logic        mem_rw_o;
	logic [15:0] mem_addr_o;
	logic        mem_ready;
	logic        mem_rdata_valid;
	logic [31:0] mem_rdata;
	logic        mem_wdata_valid_o;
	logic        mem_wdata_ack;
	logic [31:0] mem_wdata_o;
	logic        flag_hit_o;
	logic        flag_miss_o;
	logic        flag_writeback_o;
	logic        slow_mem;

	// reference cache state
	logic [31:0] shadow [65536];  // last written value of every word
	logic [10:0] m_tag   [4][8];
	logic        m_valid [4][8];
	logic        m_dirty [4][8];
	int          m_ptr   [4];     // fifo oldest way

	int          hit_count;
	int          miss_count;
	int          wb_count;
	int          req_count;
	int          cycle_count;
	int          test_num;
	int          test_errors;
	int          total_errors;
	int          tests_failed;
	logic [31:0] rng_state;

	cache_subsystem_top #(
		.CACHE_BLOCK_CAPACITY (32),
		.POLICY               ("FIFO"),
		.FIFO_DEPTH           (8)
	) cache_subsystem_top_i (
		.clock_i (clock), .resetn_i (resetn), .enable_i (1'b1),
		.core_req_i (core_req), .core_rw_i (core_rw),
		.core_addr_i (core_addr), .core_data_i (core_data),
		.core_done_o, .core_hit_o, .core_data_o,
		.mem_req_o, .mem_rw_o, .mem_addr_o, .mem_ready_i (mem_ready),
		.mem_rdata_valid_i (mem_rdata_valid), .mem_rdata_i (mem_rdata),
		.mem_wdata_valid_o, .mem_wdata_ack_i (mem_wdata_ack), .mem_wdata_o,
		.flag_hit_o, .flag_miss_o, .flag_writeback_o
	);

	tb_main_memory #(.SEED(SEED)) mem_i (
		.clock_i (clock), .slow_i (slow_mem),
		.mem_req_i (mem_req_o), .mem_rw_i (mem_rw_o), .mem_addr_i (mem_addr_o),
		.mem_ready_o (mem_ready),
		.mem_rdata_valid_o (mem_rdata_valid), .mem_rdata_o (mem_rdata),
		.mem_wdata_valid_i (mem_wdata_valid_o), .mem_wdata_ack_o (mem_wdata_ack),
		.mem_wdata_i (mem_wdata_o)
	);

	initial clock = 1'b0;
	always #(PERIOD/2) clock = ~clock;

	// pulse counters and run limit
	// --------------------
	always @(negedge clock) begin
		if (flag_hit_o) hit_count <= hit_count + 1;
		if (flag_miss_o) miss_count <= miss_count + 1;
		if (flag_writeback_o) wb_count <= wb_count + 1;
		if (mem_req_o) req_count <= req_count + 1;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: no progress within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] pattern_word(input int a);
		return 32'(a) * 32'h9e3779b1 + 32'd1;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// reference model, 4 sets of 8 ways, fifo fill order
	function automatic void predict_access(input logic [15:0] addr, input logic rw,
		input logic [31:0] wdata, output logic hit, output logic wb, output logic [31:0] rdata);
		int set;
		int way;
		int w;
		set = int'(addr[4:3]);
		way = 0;
		hit = 1'b0;
		wb  = 1'b0;
		for (w = 0; w < 8; w++) begin
			if (m_valid[set][w] && m_tag[set][w] == addr[15:5]) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			way = m_ptr[set];
			m_ptr[set] = (m_ptr[set] + 1) % 8;
			wb = m_valid[set][way] && m_dirty[set][way];  // old data already in shadow
			m_valid[set][way] = 1'b1;
			m_tag[set][way]   = addr[15:5];
			m_dirty[set][way] = 1'b0;
		end
		if (rw) begin
			shadow[addr] = wdata;
			m_dirty[set][way] = 1'b1;
		end
		rdata = shadow[addr];
	endfunction

	task automatic report_fail(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (test_errors == 0) begin
			$display("test %0d %s: passed", test_num, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", test_num, name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// one access, compared against the model
	task automatic run_access(input logic [15:0] addr, input logic rw, input logic [31:0] wdata);
		logic        exp_hit;
		logic        exp_wb;
		logic [31:0] exp_data;
		int          hits0;
		int          misses0;
		int          wbs0;
		predict_access(addr, rw, wdata, exp_hit, exp_wb, exp_data);
		@(negedge clock);
		hits0     = hit_count;
		misses0   = miss_count;
		wbs0      = wb_count;
		core_addr = addr;
		core_rw   = rw;
		core_data = wdata;
		core_req  = 1'b1;
		#(PERIOD/4);
		if (core_hit_o !== exp_hit) begin
			report_fail($sformatf("addr %h hit %b, expected %b", addr, core_hit_o, exp_hit));
		end
		@(negedge clock);
		core_req = 1'b0;
		while (core_done_o !== 1'b1) @(negedge clock);
		@(negedge clock);  // data one edge after done
		#(PERIOD/4);
		if (!rw && core_data_o !== exp_data) begin
			report_fail($sformatf("addr %h data %h, expected %h", addr, core_data_o, exp_data));
		end
		if (hit_count - hits0 != 1 || miss_count - misses0 != int'(!exp_hit)) begin
			report_fail($sformatf("addr %h hit/miss pulses %0d/%0d", addr,
				hit_count - hits0, miss_count - misses0));
		end
		if (wb_count - wbs0 != int'(exp_wb)) begin
			report_fail($sformatf("addr %h writeback pulses %0d, expected %0d", addr,
				wb_count - wbs0, int'(exp_wb)));
		end
	endtask

	// twelve blocks, nine share set 2 so evictions happen
	task automatic run_random(input int count);
		int          k;
		logic [1:0]  set;
		logic [15:0] addr;
		rng_state = SEED;  // same sequence on every call
		for (int i = 0; i < count; i++) begin
			rng_state = lcg_next(rng_state);
			k    = int'(rng_state[31:24]) % 12;
			set  = (k < 9) ? 2'd2 : 2'd3;
			addr = {11'(40 + k), set, rng_state[22:20]};
			run_access(addr, rng_state[16], lcg_next(rng_state));
		end
	endtask

	initial begin
		int          reqs0;
		int          writes0;
		logic [15:0] base;
		resetn    = 1'b0;
		core_req  = 1'b0;
		core_rw   = 1'b0;
		core_addr = '0;
		core_data = '0;
		slow_mem  = 1'b0;
		hit_count = 0;
		miss_count = 0;
		wb_count  = 0;
		req_count = 0;
		cycle_count = 0;
		test_num  = 0;
		test_errors = 0;
		total_errors = 0;
		tests_failed = 0;
		for (int i = 0; i < 65536; i++) shadow[i] = pattern_word(i);
		for (int s = 0; s < 4; s++) begin
			m_ptr[s] = 0;
			for (int w = 0; w < 8; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w]   = '0;
			end
		end
		repeat (2) @(negedge clock);
		resetn = 1'b1;

		// reset state
		@(negedge clock);
		#(PERIOD/4);
		if (core_done_o !== 1'b1) report_fail("done low after reset");
		if (mem_req_o !== 1'b0 || mem_wdata_valid_o !== 1'b0) report_fail("memory side active");
		if (flag_hit_o !== 1'b0 || flag_miss_o !== 1'b0 || flag_writeback_o !== 1'b0) begin
			report_fail("flag high after reset");
		end
		finish_test("reset state");

		// cold loads in set 0, then reloads
		for (int b = 0; b < 8; b++) run_access({11'(b), 2'd0, 3'(b)}, 1'b0, '0);
		for (int b = 0; b < 8; b++) run_access({11'(b), 2'd0, 3'(7 - b)}, 1'b0, '0);
		finish_test("cold fill and reload");

		reqs0 = req_count;
		run_access({11'd0, 2'd0, 3'd3}, 1'b1, 32'hcafe0003);
		run_access({11'd1, 2'd0, 3'd5}, 1'b1, 32'hcafe0105);
		run_access({11'd0, 2'd0, 3'd3}, 1'b0, '0);
		if (req_count != reqs0) report_fail("memory request on store hit");
		finish_test("store hit and load");

		// ninth block pushes out tag 0, way 0
		writes0 = mem_i.block_writes;
		run_access({11'd8, 2'd0, 3'd1}, 1'b0, '0);
		while (mem_i.block_writes == writes0) @(negedge clock);
		base = {11'd0, 2'd0, 3'd0};
		for (int w = 0; w < 8; w++) begin
			if (mem_i.words[base + 16'(w)] !== shadow[base + 16'(w)]) begin
				report_fail($sformatf("memory word %h holds %h, expected %h", base + 16'(w),
					mem_i.words[base + 16'(w)], shadow[base + 16'(w)]));
			end
		end
		finish_test("dirty eviction");

		run_random(200);
		finish_test("random accesses");

		slow_mem = 1'b1;  // long ready and fill gaps
		run_random(200);
		finish_test("random accesses, slow memory");

		$display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
rtl/cache_pkg.sv
rtl/cache_tag_cam.sv
rtl/cache_data_mem.sv
rtl/cache_replacement_policy.sv
rtl/block_word_fifo.sv
rtl/cache_8way_controller.sv
rtl/cache_subsystem_top.sv
test/tb_main_memory.sv
test/tb_cache_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
	--top-module tb_cache_subsystem -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_cache_subsystem > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation run failed"
	exit 1
fi

cat sim.log
if grep -q "^sim passed$" sim.log; then
	exit 0
fi
exit 1
